// ==== rv_pkg.sv ====
package rv_pkg;

  // datapath width, the subset is RV32 only
  localparam int xlen = 32;

  // major opcodes, instr[6:0]
  localparam logic [6:0] op_load   = 7'b0000011;
  localparam logic [6:0] op_store  = 7'b0100011;
  localparam logic [6:0] op_rtype  = 7'b0110011;
  localparam logic [6:0] op_branch = 7'b1100011;
  localparam logic [6:0] op_itype  = 7'b0010011;
  localparam logic [6:0] op_jal    = 7'b1101111;
  localparam logic [6:0] op_jalr   = 7'b1100111;
  localparam logic [6:0] op_auipc  = 7'b0010111;
  localparam logic [6:0] op_lui    = 7'b0110111;
  localparam logic [6:0] op_system = 7'b1110011;
  // all-zero word seen out of a cleared memory
  localparam logic [6:0] op_reset  = 7'b0000000;

  // alu operand a source
  localparam logic [1:0] alu_a_rs1  = 2'b00;
  localparam logic [1:0] alu_a_zero = 2'b01;

  // alu operand b source
  localparam logic alu_b_rs2 = 1'b0;
  localparam logic alu_b_imm = 1'b1;

  // alu class, refined by funct3/funct7 in the alu decoder
  localparam logic [1:0] alu_instr_add = 2'b00;
  localparam logic [1:0] alu_instr_sub = 2'b01;
  localparam logic [1:0] alu_instr_fn3 = 2'b10;

  // write-back source
  localparam logic [1:0] res_alu = 2'b00;
  localparam logic [1:0] res_mem = 2'b01;
  localparam logic [1:0] res_pc4 = 2'b10;
  // pc + imm, or the jalr target
  localparam logic [1:0] res_tgt = 2'b11;

  // immediate format select
  localparam logic [2:0] imm_i = 3'd0;
  localparam logic [2:0] imm_s = 3'd1;
  localparam logic [2:0] imm_b = 3'd2;
  localparam logic [2:0] imm_u = 3'd3;
  localparam logic [2:0] imm_j = 3'd4;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and
  } alu_op_t;

  // one view per base format, fields msb first
  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } r;
    struct packed {
      logic [11:0] imm_11_0;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } i;
    struct packed {
      logic [6:0] imm_11_5;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] imm_4_0;
      logic [6:0] opcode;
    } s;
    struct packed {
      logic       imm_12;
      logic [5:0] imm_10_5;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [3:0] imm_4_1;
      logic       imm_11;
      logic [6:0] opcode;
    } b;
    struct packed {
      logic [19:0] imm_31_12;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } u;
    struct packed {
      logic       imm_20;
      logic [9:0] imm_10_1;
      logic       imm_11;
      logic [7:0] imm_19_12;
      logic [4:0] rd;
      logic [6:0] opcode;
    } j;
    logic [31:0] raw;
  } instr_u;

endpackage

// ==== rv_ctrl_if.sv ====
`timescale 1ns/100ps

interface rv_ctrl_if
  import rv_pkg::*;
();

  // register file and memory enables
  logic            reg_write;
  logic            mem_write;

  // alu operand selects and resolved operation
  logic [1:0]      alu_a_src;
  logic            alu_b_src;
  alu_op_t         alu_op;

  // write-back select
  logic [1:0]      res_src;

  // control flow
  logic            is_branch;
  logic            is_jump;
  logic [2:0]      branch_funct3;

  // already selected by format
  logic [xlen-1:0] imm;

  modport dec(
    output reg_write, mem_write, alu_a_src, alu_b_src, alu_op,
    output res_src, is_branch, is_jump, branch_funct3, imm
  );

  modport dp(
    input reg_write, mem_write, alu_a_src, alu_b_src, alu_op,
    input res_src, is_branch, is_jump, branch_funct3, imm
  );

endinterface

// ==== rv_alu_dec.sv ====
`timescale 1ns/100ps

module rv_alu_dec
  import rv_pkg::*;
(
  input  logic [1:0] alu_instr,
  input  logic [2:0] funct3,
  input  logic       funct7_5,
  input  logic       is_rtype,
  output alu_op_t    alu_op
);

  always_comb begin
    case (alu_instr)
      alu_instr_add: alu_op = alu_add;
      // branches compare through a subtract
      alu_instr_sub: alu_op = alu_sub;
      alu_instr_fn3: begin
        case (funct3)
          // addi has no sub form, instr[30] is immediate there
          3'b000:  alu_op = (is_rtype && funct7_5) ? alu_sub : alu_add;
          3'b001:  alu_op = alu_sll;
          3'b010:  alu_op = alu_slt;
          3'b011:  alu_op = alu_sltu;
          3'b100:  alu_op = alu_xor;
          // srai and sra share the funct7 bit
          3'b101:  alu_op = funct7_5 ? alu_sra : alu_srl;
          3'b110:  alu_op = alu_or;
          default: alu_op = alu_and;
        endcase
      end
      default: alu_op = alu_add;
    endcase
  end

endmodule

// ==== rv_alu.sv ====
`timescale 1ns/100ps

module rv_alu
  import rv_pkg::*;
(
  input  logic [31:0] a,
  input  logic [31:0] b,
  input  alu_op_t     alu_op,
  input  logic [2:0]  branch_funct3,
  output logic [31:0] result,
  output logic        take_branch
);

  logic [4:0] shamt;
  logic       eq;
  logic       lt;
  logic       ltu;

  // only the low five bits shift on rv32
  assign shamt = b[4:0];

  assign eq  = (a == b);
  assign lt  = ($signed(a) < $signed(b));
  assign ltu = (a < b);

  always_comb begin
    case (alu_op)
      alu_add:  result = a + b;
      alu_sub:  result = a - b;
      alu_sll:  result = a << shamt;
      alu_slt:  result = {31'b0, lt};
      alu_sltu: result = {31'b0, ltu};
      alu_xor:  result = a ^ b;
      alu_srl:  result = a >> shamt;
      alu_sra:  result = $signed(a) >>> shamt;
      alu_or:   result = a | b;
      alu_and:  result = a & b;
      default:  result = a + b;
    endcase
  end

  // beq bne blt bge bltu bgeu by funct3
  always_comb begin
    case (branch_funct3)
      3'b000:  take_branch = eq;
      3'b001:  take_branch = !eq;
      3'b100:  take_branch = lt;
      3'b101:  take_branch = !lt;
      3'b110:  take_branch = ltu;
      3'b111:  take_branch = !ltu;
      default: take_branch = 1'b0;
    endcase
  end

endmodule

// ==== rv_idec.sv ====
`timescale 1ns/100ps

module rv_idec
  import rv_pkg::*;
(
  input  logic [31:0] instr,
  rv_ctrl_if.dec      ctrl,
  output logic [4:0]  rd,
  output logic [4:0]  rs1,
  output logic [4:0]  rs2
);

  // short names so each table row reads at a glance
  localparam logic       y     = 1'b1;
  localparam logic       n     = 1'b0;
  localparam logic [1:0] a_r1  = alu_a_rs1;
  localparam logic [1:0] a_z0  = alu_a_zero;
  localparam logic       b_r2  = alu_b_rs2;
  localparam logic       b_im  = alu_b_imm;
  localparam logic [1:0] c_add = alu_instr_add;
  localparam logic [1:0] c_sub = alu_instr_sub;
  localparam logic [1:0] c_fn3 = alu_instr_fn3;
  localparam logic [1:0] r_alu = res_alu;
  localparam logic [1:0] r_mem = res_mem;
  localparam logic [1:0] r_pc4 = res_pc4;
  localparam logic [1:0] r_tgt = res_tgt;
  localparam logic [2:0] im_i  = imm_i;
  localparam logic [2:0] im_s  = imm_s;
  localparam logic [2:0] im_b  = imm_b;
  localparam logic [2:0] im_u  = imm_u;
  localparam logic [2:0] im_j  = imm_j;

  instr_u          word;
  logic [6:0]      opcode;
  logic [2:0]      funct3;
  logic [13:0]     ctrl_word;
  logic [1:0]      alu_instr;
  logic [2:0]      imm_type;
  logic            is_branch;
  logic [xlen-1:0] imm_i_val;
  logic [xlen-1:0] imm_s_val;
  logic [xlen-1:0] imm_b_val;
  logic [xlen-1:0] imm_u_val;
  logic [xlen-1:0] imm_j_val;

  assign word   = instr;
  // opcode, rd and funct3 sit in the same place in every format
  assign opcode = word.r.opcode;
  assign funct3 = word.r.funct3;
  assign rd     = word.r.rd;
  assign rs1    = word.r.rs1;
  assign rs2    = word.r.rs2;

  // jal runs the alu from zero so that jalr is the only jump reading rs1
  always_comb begin
    case (opcode)
      //                      r  m  a     b     alu    res    imm   b  j
      op_load:   ctrl_word = {y, n, a_r1, b_im, c_add, r_mem, im_i, n, n};
      op_store:  ctrl_word = {n, y, a_r1, b_im, c_add, r_alu, im_s, n, n};
      op_rtype:  ctrl_word = {y, n, a_r1, b_r2, c_fn3, r_alu, im_i, n, n};
      op_branch: ctrl_word = {n, n, a_r1, b_r2, c_sub, r_alu, im_b, y, n};
      op_itype:  ctrl_word = {y, n, a_r1, b_im, c_fn3, r_alu, im_i, n, n};
      op_jal:    ctrl_word = {y, n, a_z0, b_im, c_add, r_pc4, im_j, n, y};
      op_jalr:   ctrl_word = {y, n, a_r1, b_im, c_add, r_pc4, im_i, n, y};
      op_auipc:  ctrl_word = {y, n, a_z0, b_im, c_add, r_tgt, im_u, n, n};
      op_lui:    ctrl_word = {y, n, a_z0, b_im, c_add, r_alu, im_u, n, n};
      // no-op rows, nothing written and pc + 4
      op_system: ctrl_word = {n, n, a_z0, b_r2, c_add, r_alu, im_i, n, n};
      op_reset:  ctrl_word = {n, n, a_z0, b_r2, c_add, r_alu, im_i, n, n};
      default:   ctrl_word = {n, n, a_z0, b_r2, c_add, r_alu, im_i, n, n};
    endcase
  end

  assign {ctrl.reg_write, ctrl.mem_write, ctrl.alu_a_src, ctrl.alu_b_src,
          alu_instr, ctrl.res_src, imm_type, is_branch, ctrl.is_jump} = ctrl_word;

  assign ctrl.is_branch     = is_branch;
  // compare kind only matters on branches
  assign ctrl.branch_funct3 = is_branch ? funct3 : 3'b000;

  rv_alu_dec alu_dec (
    .alu_instr (alu_instr),
    .funct3    (funct3),
    .funct7_5  (word.r.funct7[5]),
    .is_rtype  (opcode == op_rtype),
    .alu_op    (ctrl.alu_op)
  );

  // sign comes from instr[31] in every view
  assign imm_i_val = {{(xlen - 12){word.i.imm_11_0[11]}}, word.i.imm_11_0};
  assign imm_s_val = {{(xlen - 12){word.s.imm_11_5[6]}}, word.s.imm_11_5, word.s.imm_4_0};
  assign imm_b_val = {{(xlen - 13){word.b.imm_12}}, word.b.imm_12, word.b.imm_11,
                      word.b.imm_10_5, word.b.imm_4_1, 1'b0};
  assign imm_u_val = {word.u.imm_31_12, 12'b0};
  assign imm_j_val = {{(xlen - 21){word.j.imm_20}}, word.j.imm_20, word.j.imm_19_12,
                      word.j.imm_11, word.j.imm_10_1, 1'b0};

  // only the selected immediate leaves the decoder
  always_comb begin
    case (imm_type)
      imm_s:   ctrl.imm = imm_s_val;
      imm_b:   ctrl.imm = imm_b_val;
      imm_u:   ctrl.imm = imm_u_val;
      imm_j:   ctrl.imm = imm_j_val;
      default: ctrl.imm = imm_i_val;
    endcase
  end

endmodule

// ==== rv_regfile.sv ====
`timescale 1ns/100ps

module rv_regfile (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        we,
  input  logic [4:0]  waddr,
  input  logic [4:0]  raddr1,
  input  logic [4:0]  raddr2,
  input  logic [31:0] wdata,
  output logic [31:0] rdata1,
  output logic [31:0] rdata2
);

  // entry 0 exists but is never written
  logic [31:0] regs [32];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int k = 0; k < 32; k++) begin
        regs[k] <= '0;
      end
    end else if (we && (waddr != 5'd0)) begin
      regs[waddr] <= wdata;
    end
  end

  // read before write, a same-cycle write shows up next cycle
  assign rdata1 = (raddr1 == 5'd0) ? 32'd0 : regs[raddr1];
  assign rdata2 = (raddr2 == 5'd0) ? 32'd0 : regs[raddr2];

endmodule

// ==== rv_core.sv ====
`timescale 1ns/100ps

module rv_core
  import rv_pkg::*;
#(
  parameter logic [31:0] reset_pc = 32'h0000_0000
) (
  input  logic        clk,
  input  logic        rst_n,
  output logic [31:0] imem_addr,
  input  logic [31:0] imem_rdata,
  output logic [31:0] dmem_addr,
  output logic [31:0] dmem_wdata,
  output logic        dmem_we,
  input  logic [31:0] dmem_rdata
);

  logic [xlen-1:0] pc;
  logic [xlen-1:0] pc_plus4;
  logic [xlen-1:0] pc_target;
  logic [xlen-1:0] pc_next;
  logic [4:0]      rd;
  logic [4:0]      rs1;
  logic [4:0]      rs2;
  logic [xlen-1:0] rs1_data;
  logic [xlen-1:0] rs2_data;
  logic [xlen-1:0] alu_a;
  logic [xlen-1:0] alu_b;
  logic [xlen-1:0] alu_result;
  logic [xlen-1:0] result;
  logic            take_branch;
  logic            is_jalr;
  logic            redirect;

  rv_ctrl_if ctrl ();

  rv_idec idec (
    .instr (imem_rdata),
    .ctrl  (ctrl.dec),
    .rd    (rd),
    .rs1   (rs1),
    .rs2   (rs2)
  );

  rv_regfile regfile (
    .clk    (clk),
    .rst_n  (rst_n),
    .we     (ctrl.reg_write),
    .waddr  (rd),
    .raddr1 (rs1),
    .raddr2 (rs2),
    .wdata  (result),
    .rdata1 (rs1_data),
    .rdata2 (rs2_data)
  );

  // zero operand serves lui and keeps jal/auipc off rs1
  assign alu_a = (ctrl.alu_a_src == alu_a_zero) ? '0 : rs1_data;
  assign alu_b = (ctrl.alu_b_src == alu_b_imm) ? ctrl.imm : rs2_data;

  rv_alu alu (
    .a             (alu_a),
    .b             (alu_b),
    .alu_op        (ctrl.alu_op),
    .branch_funct3 (ctrl.branch_funct3),
    .result        (alu_result),
    .take_branch   (take_branch)
  );

  // jalr is the only jump that reads rs1
  assign is_jalr = ctrl.is_jump && (ctrl.alu_a_src == alu_a_rs1);

  assign pc_plus4  = pc + 32'd4;
  // jalr drops bit 0 of rs1 + imm
  assign pc_target = is_jalr ? {alu_result[xlen-1:1], 1'b0} : pc + ctrl.imm;

  assign redirect = ctrl.is_jump || (ctrl.is_branch && take_branch);
  assign pc_next  = redirect ? pc_target : pc_plus4;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc <= reset_pc;
    end else begin
      pc <= pc_next;
    end
  end

  // write-back select
  always_comb begin
    case (ctrl.res_src)
      res_mem: result = dmem_rdata;
      res_pc4: result = pc_plus4;
      res_tgt: result = pc_target;
      default: result = alu_result;
    endcase
  end

  assign imem_addr  = pc;
  assign dmem_addr  = alu_result;
  assign dmem_wdata = rs2_data;
  // no stores reach memory while the core is held in reset
  assign dmem_we    = ctrl.mem_write && rst_n;

endmodule

// ==== rv_core_assert.sv ====
`timescale 1ns/100ps

module rv_core_assert
  import rv_pkg::*;
(
  input logic        clk,
  input logic        rst_n,
  input logic [31:0] imem_addr,
  input logic [31:0] imem_rdata,
  input logic        dmem_we
);

  // only control-flow words may leave the pc where it was
  logic flow_op;

  assign flow_op = (imem_rdata[6:0] == op_jal) || (imem_rdata[6:0] == op_jalr) ||
                   (imem_rdata[6:0] == op_branch);

  no_store_in_reset: assert property (@(posedge clk) !rst_n |-> !dmem_we)
    else $error("dmem_we high while rst_n is low");

  pc_aligned: assert property (@(posedge clk) disable iff (!rst_n)
    imem_addr[1:0] == 2'b00)
    else $error("imem_addr %h is not word aligned", imem_addr);

  // one retire per edge, a jump or branch onto itself is the exception
  pc_advances: assert property (@(posedge clk) disable iff (!rst_n)
    $past(rst_n) |-> (imem_addr != $past(imem_addr)) || $past(flow_op))
    else $error("imem_addr stuck at %h", imem_addr);

endmodule

bind rv_core rv_core_assert core_checks (
  .clk        (clk),
  .rst_n      (rst_n),
  .imem_addr  (imem_addr),
  .imem_rdata (imem_rdata),
  .dmem_we    (dmem_we)
);

// ==== tb_rv_core.sv ====
`timescale 1ns/100ps

module tb_rv_core;

  localparam logic [31:0] reset_pc = 32'h0000_0080;
  localparam int n_tests = 4;
  localparam int n_instr = 500;
  // reset plus one cycle per instruction for every test, then some slack
  localparam int max_cycles = n_tests * (n_instr + 8) + 100;

  logic        clk = 1'b0;
  logic        rst_n = 1'b0;
  logic [31:0] imem_addr;
  logic [31:0] imem_rdata;
  logic [31:0] dmem_addr;
  logic [31:0] dmem_wdata;
  logic        dmem_we;
  logic [31:0] dmem_rdata;

  // both memories wrap on address bits [7:2]
  logic [31:0] imem [64];
  logic [31:0] dmem [64];
  // instruction-set model state
  logic [31:0] m_dmem [64];
  logic [31:0] m_regs [32];
  logic [31:0] m_pc;
  logic [31:0] lcg_state = 32'h46c6542a;
  int          cycles = 0;
  int          err_count = 0;
  int          check_count = 0;
  int          failed_tests = 0;

  always #5 clk = ~clk;

  rv_core #(.reset_pc(reset_pc)) i_dut (
    .clk        (clk),
    .rst_n      (rst_n),
    .imem_addr  (imem_addr),
    .imem_rdata (imem_rdata),
    .dmem_addr  (dmem_addr),
    .dmem_wdata (dmem_wdata),
    .dmem_we    (dmem_we),
    .dmem_rdata (dmem_rdata)
  );

  assign imem_rdata = imem[imem_addr[7:2]];
  assign dmem_rdata = dmem[dmem_addr[7:2]];

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= max_cycles) begin
      $display("timeout: the run did not finish within %0d cycles", max_cycles);
      $display("Simulation failed");
      $finish;
    end
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // low lcg bits repeat quickly, so draw from the upper ones
  function automatic int unsigned rand_below(input int unsigned n);
    return (lcg_next() >> 8) % n;
  endfunction

  function automatic logic [31:0] rand_word();
    logic [31:0] hi;
    logic [31:0] lo;
    hi = lcg_next();
    lo = lcg_next();
    return {hi[31:16], lo[31:16]};
  endfunction

  // x0..x7 three times out of four so results feed later instructions
  function automatic logic [4:0] pick_reg();
    if (rand_below(4) != 0) return 5'(rand_below(8));
    return 5'(rand_below(32));
  endfunction

  function automatic logic [31:0] gen_instr();
    logic [31:0] w;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  f3;
    logic [11:0] imm;
    logic [12:0] boff;
    logic [20:0] joff;
    w = rand_word();
    rd = pick_reg();
    rs1 = pick_reg();
    rs2 = pick_reg();
    f3 = 3'(rand_below(8));
    imm = 12'(rand_below(4096));
    case (rand_below(17))
      0, 1: return {imm, rs1, 3'b010, rd, 7'b0000011};
      2, 3: return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
      4, 5: return {1'b0, w[30], 5'b0, rs2, rs1, f3, rd, 7'b0110011};
      6, 7: begin
        // shifts keep a legal upper field, bit 30 picks srai
        if (f3 == 3'b001 || f3 == 3'b101) imm[11:5] = {1'b0, imm[10], 5'b0};
        return {imm, rs1, f3, rd, 7'b0010011};
      end
      8, 9: begin
        // forward and word aligned so no branch spins on itself
        boff = 13'(4 * (1 + rand_below(16)));
        if (f3 == 3'b010 || f3 == 3'b011) f3 = f3 + 3'b100;
        return {boff[12], boff[10:5], rs2, rs1, f3, boff[4:1], boff[11], 7'b1100011};
      end
      10: begin
        joff = 21'(4 * (1 + rand_below(8)));
        return {joff[20], joff[10:1], joff[11], joff[19:12], rd, 7'b1101111};
      end
      // absolute jump off x0, bit 0 of the offset must be dropped
      11: return {4'b0, 6'(rand_below(64)), 1'b0, w[0], 5'd0, 3'b000, rd, 7'b1100111};
      12: return {w[31:12], rd, 7'b0010111};
      13: return {w[31:12], rd, 7'b0110111};
      14: return {w[31:7], 7'b1110011};
      15: return {w[31:7], 7'b0000000};
      // custom-0 opcode, outside the subset
      default: return {w[31:7], 7'b0001011};
    endcase
  endfunction

  function automatic logic [31:0] alu_model(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
    case (f3)
      3'b000: return alt ? a - b : a + b;
      3'b001: return a << b[4:0];
      3'b010: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'b011: return (a < b) ? 32'd1 : 32'd0;
      3'b100: return a ^ b;
      3'b101: begin
        if (alt) return $signed(a) >>> b[4:0];
        return a >> b[4:0];
      end
      3'b110: return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic branch_taken(input logic [2:0] f3, input logic [31:0] a,
                                        input logic [31:0] b);
    case (f3)
      3'b000: return a == b;
      3'b001: return a != b;
      3'b100: return $signed(a) < $signed(b);
      3'b101: return $signed(a) >= $signed(b);
      3'b110: return a < b;
      3'b111: return a >= b;
      default: return 1'b0;
    endcase
  endfunction

  // fresh program and data, the model restarts from reset_pc
  task automatic fill_memories();
    logic [31:0] w;
    for (int i = 0; i < 64; i++) begin
      w = rand_word();
      imem[i] <= gen_instr();
      dmem[i] <= w;
      m_dmem[i] = w;
    end
    for (int r = 0; r < 32; r++) begin
      m_regs[r] = 32'd0;
    end
    m_pc = reset_pc;
  endtask

  task automatic expect_equal(input string what, input logic [31:0] got,
                              input logic [31:0] exp);
    check_count++;
    assert (got == exp) else begin
      err_count++;
      $display("Fail at %0d ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  // runs one instruction on the model and checks what the core shows for it
  task automatic check_and_step();
    logic [31:0] ins;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] i_imm;
    logic [31:0] s_imm;
    logic [31:0] b_imm;
    logic [31:0] u_imm;
    logic [31:0] j_imm;
    logic [31:0] next;
    logic [31:0] wval;
    logic [31:0] ea;
    logic        wr;
    logic        st;
    ins = imem[m_pc[7:2]];
    a = m_regs[ins[19:15]];
    b = m_regs[ins[24:20]];
    i_imm = {{20{ins[31]}}, ins[31:20]};
    s_imm = {{20{ins[31]}}, ins[31:25], ins[11:7]};
    b_imm = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
    u_imm = {ins[31:12], 12'b0};
    j_imm = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
    next = m_pc + 32'd4;
    wval = 32'd0;
    ea = 32'd0;
    wr = 1'b0;
    st = 1'b0;
    expect_equal("imem_addr", imem_addr, m_pc);
    case (ins[6:0])
      7'b0000011: begin
        wr = 1'b1;
        ea = a + i_imm;
        wval = m_dmem[ea[7:2]];
      end
      7'b0100011: begin
        st = 1'b1;
        ea = a + s_imm;
      end
      7'b0110011: begin
        wr = 1'b1;
        wval = alu_model(ins[14:12], ins[30], a, b);
      end
      7'b0010011: begin
        wr = 1'b1;
        // bit 30 belongs to the immediate except on srai
        wval = alu_model(ins[14:12], ins[30] && (ins[14:12] == 3'b101), a, i_imm);
      end
      7'b1100011: if (branch_taken(ins[14:12], a, b)) next = m_pc + b_imm;
      7'b1101111: begin
        wr = 1'b1;
        wval = m_pc + 32'd4;
        next = m_pc + j_imm;
      end
      7'b1100111: begin
        wr = 1'b1;
        wval = m_pc + 32'd4;
        next = (a + i_imm) & ~32'd1;
      end
      7'b0010111: begin
        wr = 1'b1;
        wval = m_pc + u_imm;
      end
      7'b0110111: begin
        wr = 1'b1;
        wval = u_imm;
      end
      // system, reset word and unknown opcodes only move on
      default: ;
    endcase
    expect_equal("dmem_we", {31'b0, dmem_we}, {31'b0, st});
    if (st) begin
      expect_equal("dmem_addr", dmem_addr, ea);
      expect_equal("dmem_wdata", dmem_wdata, b);
      m_dmem[ea[7:2]] = b;
    end
    if (wr && (ins[11:7] != 5'd0)) m_regs[ins[11:7]] = wval;
    m_pc = next;
  endtask

  initial begin
    int errs_before;
    for (int t = 0; t < n_tests; t++) begin
      errs_before = err_count;
      rst_n <= 1'b0;
      fill_memories();
      @(negedge clk);
      expect_equal("dmem_we in reset", {31'b0, dmem_we}, 32'd0);
      repeat (8) @(posedge clk);
      rst_n <= 1'b1;
      for (int i = 0; i < n_instr; i++) begin
        @(negedge clk);
        check_and_step();
        // pc moves in the nba region, so dmem_we still belongs to this instruction
        @(posedge clk);
        if (dmem_we) dmem[dmem_addr[7:2]] <= dmem_wdata;
      end
      if (err_count != errs_before) failed_tests++;
      $display("test %0d: %0d instructions, %0d errors", t, n_instr, err_count - errs_before);
    end
    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             n_tests, failed_tests, check_count, err_count);
    if (err_count == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== src.f ====
rv_pkg.sv
rv_ctrl_if.sv
rv_alu_dec.sv
rv_alu.sv
rv_idec.sv
rv_regfile.sv
rv_core.sv
rv_core_assert.sv
tb_rv_core.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the core testbench with verilator and runs it, the log gives the verdict

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -f src.f --top-module tb_rv_core
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/Vtb_rv_core > "$log" 2>&1
status=$?
cat "$log"

# a failed concurrent assertion stops the run with a nonzero status
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Simulation failed" "$log"; then
  echo "testbench reported errors, see $log"
  exit 1
fi

echo "run clean, see $log"
exit 0
